// File: common/soc_pkg.sv
`default_nettype none

package soc_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// ========================================
	// Address map
	// ========================================
	localparam logic [ADDR_W-1:0] RAM_BASE    = 32'h0001_0000;
	localparam logic [ADDR_W-1:0] RAM_SPAN    = 32'h0001_0000;
	localparam logic [ADDR_W-1:0] PERIPH_BASE = 32'h5000_0000;
	localparam logic [ADDR_W-1:0] PERIPH_SPAN = 32'h0000_0040;

	// Offset bits inside the peripheral window
	localparam int PERIPH_OFF_W = 6;

	// Peripheral register offsets
	localparam logic [PERIPH_OFF_W-1:0] REG_LED     = 6'h00;
	localparam logic [PERIPH_OFF_W-1:0] REG_COUNT   = 6'h10;
	localparam logic [PERIPH_OFF_W-1:0] REG_COMPARE = 6'h14;
	localparam logic [PERIPH_OFF_W-1:0] REG_STATUS  = 6'h18;

	// Board LED count
	localparam int LED_W = 10;

endpackage

`default_nettype wire

// File: common/bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Request level held until a one-cycle ready pulse
// rw high means write
interface bus_if
	import soc_pkg::*;
();

	logic              request;
	logic              rw;
	logic [ADDR_W-1:0] address;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;
	logic              ready;

	modport master (
		output request, rw, address, wdata,
		input  rdata, ready
	);

	modport slave (
		input  request, rw, address, wdata,
		output rdata, ready
	);

endinterface

`default_nettype wire

// File: source/bus_access.sv
`timescale 1ns/1ps
`default_nettype none

module bus_access
	import soc_pkg::*;
(
	input  wire logic              clock,
	input  wire logic              i_rst,

	// Port A, instruction fetch
	input  wire logic              i_pa_request,
	input  wire logic [ADDR_W-1:0] i_pa_address,
	output logic                   o_pa_ready,
	output logic      [DATA_W-1:0] o_pa_rdata,

	// Port B, data
	input  wire logic              i_pb_request,
	input  wire logic              i_pb_rw,
	input  wire logic [ADDR_W-1:0] i_pb_address,
	input  wire logic [DATA_W-1:0] i_pb_wdata,
	output logic                   o_pb_ready,
	output logic      [DATA_W-1:0] o_pb_rdata,

	bus_if.master                  bus
);

	typedef enum logic [1:0] {GNT_IDLE, GNT_A, GNT_B} grant_t;

	grant_t grant;

	// One access in flight, port B wins ties
	always_ff @(posedge clock)
	begin
		if (i_rst)
			grant <= GNT_IDLE;
		else if (grant == GNT_IDLE)
		begin
			if (i_pb_request)
				grant <= GNT_B;
			else if (i_pa_request)
				grant <= GNT_A;
		end
		else if (bus.ready)
			grant <= GNT_IDLE;
	end

	// Steer the granted port onto the bus
	assign bus.request = (grant != GNT_IDLE);
	assign bus.rw      = (grant == GNT_B) ? i_pb_rw : 1'b0;
	assign bus.address = (grant == GNT_B) ? i_pb_address :
		(grant == GNT_A) ? i_pa_address : '0;
	assign bus.wdata   = (grant == GNT_B) ? i_pb_wdata : '0;

	// Return path to the owner only
	assign o_pa_ready = bus.ready && (grant == GNT_A);
	assign o_pb_ready = bus.ready && (grant == GNT_B);
	assign o_pa_rdata = (grant == GNT_A) ? bus.rdata : '0;
	assign o_pb_rdata = (grant == GNT_B) ? bus.rdata : '0;

	// Slaves only answer a live request
	assert property (@(posedge clock) disable iff (i_rst) bus.ready |-> bus.request);

	// A ready belongs to an access that this port already owned
	assert property (@(posedge clock) disable iff (i_rst)
		$rose(o_pa_ready) |-> $past(grant) == GNT_A);
	assert property (@(posedge clock) disable iff (i_rst)
		$rose(o_pb_ready) |-> $past(grant) == GNT_B);

endmodule

`default_nettype wire

// File: source/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder
	import soc_pkg::*;
(
	input  wire logic clock,
	input  wire logic i_rst,

	bus_if.slave      cpu,
	bus_if.master     ram,
	bus_if.master     periph
);

	logic ram_sel;
	logic periph_sel;
	logic unmapped_ready;

	// ========================================
	// Window compare
	// ========================================
	assign ram_sel = (cpu.address >= RAM_BASE) &&
		(cpu.address < RAM_BASE + RAM_SPAN);
	assign periph_sel = (cpu.address >= PERIPH_BASE) &&
		(cpu.address < PERIPH_BASE + PERIPH_SPAN);

	// Forward with window-relative addresses
	assign ram.request = cpu.request && ram_sel;
	assign ram.rw      = cpu.rw;
	assign ram.address = cpu.address - RAM_BASE;
	assign ram.wdata   = cpu.wdata;

	assign periph.request = cpu.request && periph_sel;
	assign periph.rw      = cpu.rw;
	assign periph.address = cpu.address - PERIPH_BASE;
	assign periph.wdata   = cpu.wdata;

	// Nothing mapped here, answer anyway so the master moves on
	always_ff @(posedge clock)
	begin
		if (i_rst)
			unmapped_ready <= 1'b0;
		else
			unmapped_ready <= cpu.request && !ram_sel && !periph_sel && !unmapped_ready;
	end

	// ========================================
	// Return mux
	// ========================================
	assign cpu.ready = ram_sel ? ram.ready :
		periph_sel ? periph.ready : unmapped_ready;
	assign cpu.rdata = ram_sel ? ram.rdata :
		periph_sel ? periph.rdata : '0;

	assert property (@(posedge clock) disable iff (i_rst)
		cpu.request |-> !(ram_sel && periph_sel));

endmodule

`default_nettype wire

// File: source/block_ram.sv
`timescale 1ns/1ps
`default_nettype none

module block_ram
	import soc_pkg::*;
#(
	parameter int RAM_DEPTH = 1024
)
(
	input  wire logic clock,
	input  wire logic i_rst,

	bus_if.slave      bus
);

	localparam int IDX_W = $clog2(RAM_DEPTH);

	logic [DATA_W-1:0] mem [RAM_DEPTH];
	logic [DATA_W-1:0] rdata_q;
	logic              ready_q;
	logic [IDX_W-1:0]  word_idx;

	// Word address, upper bits alias
	assign word_idx = bus.address[IDX_W+1:2];

	always_ff @(posedge clock)
	begin
		if (i_rst)
			ready_q <= 1'b0;
		else
			ready_q <= bus.request && !ready_q;
	end

	always_ff @(posedge clock)
	begin
		if (bus.request && !ready_q)
		begin
			if (bus.rw)
				mem[word_idx] <= bus.wdata;
			rdata_q <= mem[word_idx];
		end
	end

	assign bus.ready = ready_q;
	assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// File: peripherals/periph_regs.sv
`timescale 1ns/1ps
`default_nettype none

module periph_regs
	import soc_pkg::*;
(
	input  wire logic              clock,
	input  wire logic              i_rst,

	bus_if.slave                   bus,

	input  wire logic [DATA_W-1:0] i_count,
	input  wire logic              i_match,
	output logic      [DATA_W-1:0] o_compare,
	output logic      [LED_W-1:0]  o_led
);

	logic [PERIPH_OFF_W-1:0] offset;
	logic                    access;
	logic                    ready_q;
	logic                    match_flag;
	logic [DATA_W-1:0]       rdata_q;

	assign offset = bus.address[PERIPH_OFF_W-1:0];
	assign access = bus.request && !ready_q;

	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			ready_q    <= 1'b0;
			o_led      <= '0;
			o_compare  <= '0;
			match_flag <= 1'b0;
		end
		else
		begin
			ready_q <= access;
			if (access && bus.rw && offset == REG_LED)
				o_led <= bus.wdata[LED_W-1:0];
			if (access && bus.rw && offset == REG_COMPARE)
				o_compare <= bus.wdata;
			// Sticky, a new match beats a clear in the same cycle
			if (i_match)
				match_flag <= 1'b1;
			else if (access && bus.rw && offset == REG_STATUS && bus.wdata[0])
				match_flag <= 1'b0;
		end
	end

	// Read mux, unknown offsets read zero
	always_ff @(posedge clock)
	begin
		if (access)
		begin
			case (offset)
				REG_LED:     rdata_q <= DATA_W'(o_led);
				REG_COUNT:   rdata_q <= i_count;
				REG_COMPARE: rdata_q <= o_compare;
				REG_STATUS:  rdata_q <= DATA_W'(match_flag);
				default:     rdata_q <= '0;
			endcase
		end
	end

	assign bus.ready = ready_q;
	assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// File: peripherals/cycle_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_timer
	import soc_pkg::*;
#(
	parameter int TICK_DIV = 4
)
(
	input  wire logic              clock,
	input  wire logic              i_rst,
	input  wire logic [DATA_W-1:0] i_compare,
	output logic      [DATA_W-1:0] o_count,
	output logic                   o_match
);

	localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [PRE_W-1:0] prescale;
	logic             tick;

	assign tick = (prescale == PRE_W'(TICK_DIV - 1));

	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			prescale <= '0;
			o_count  <= '0;
			o_match  <= 1'b0;
		end
		else
		begin
			prescale <= tick ? '0 : prescale + 1'b1;
			// Match pulse lines up with the new count value
			o_match  <= tick && (o_count + 1'b1 == i_compare);
			if (tick)
				o_count <= o_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top
	import soc_pkg::*;
#(
	parameter int RAM_DEPTH = 1024,
	parameter int TICK_DIV  = 4
)
(
	input  wire logic              clock,
	input  wire logic              i_rst,

	// Instruction port
	input  wire logic              i_ia_request,
	input  wire logic [ADDR_W-1:0] i_ia_address,
	output logic                   o_ia_ready,
	output logic      [DATA_W-1:0] o_ia_rdata,

	// Data port
	input  wire logic              i_db_request,
	input  wire logic              i_db_rw,
	input  wire logic [ADDR_W-1:0] i_db_address,
	input  wire logic [DATA_W-1:0] i_db_wdata,
	output logic                   o_db_ready,
	output logic      [DATA_W-1:0] o_db_rdata,

	output logic      [LED_W-1:0]  o_led
);

	bus_if shared_bus ();
	bus_if ram_bus ();
	bus_if periph_bus ();

	logic [DATA_W-1:0] timer_count;
	logic [DATA_W-1:0] timer_compare;
	logic              timer_match;

	// ========================================
	// Single port bus
	// ========================================
	bus_access u_access (
		.clock        (clock),
		.i_rst        (i_rst),
		.i_pa_request (i_ia_request),
		.i_pa_address (i_ia_address),
		.o_pa_ready   (o_ia_ready),
		.o_pa_rdata   (o_ia_rdata),
		.i_pb_request (i_db_request),
		.i_pb_rw      (i_db_rw),
		.i_pb_address (i_db_address),
		.i_pb_wdata   (i_db_wdata),
		.o_pb_ready   (o_db_ready),
		.o_pb_rdata   (o_db_rdata),
		.bus          (shared_bus)
	);

	bus_decoder u_decoder (.clock(clock), .i_rst(i_rst), .cpu(shared_bus),
		.ram(ram_bus), .periph(periph_bus));

	block_ram #(.RAM_DEPTH(RAM_DEPTH)) u_ram (.clock(clock), .i_rst(i_rst), .bus(ram_bus));

	// Peripherals
	periph_regs u_periph (.clock(clock), .i_rst(i_rst), .bus(periph_bus),
		.i_count(timer_count), .i_match(timer_match), .o_compare(timer_compare),
		.o_led(o_led));

	cycle_timer #(.TICK_DIV(TICK_DIV)) u_timer (.clock(clock), .i_rst(i_rst),
		.i_compare(timer_compare), .o_count(timer_count), .o_match(timer_match));

endmodule

`default_nettype wire

// File: tb/soc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module soc_checker
	import soc_pkg::*;
#(
	parameter int RAM_DEPTH = 1024
)
(
	input  wire logic              clock,
	input  wire logic              i_rst,
	input  wire logic [ADDR_W-1:0] i_ia_address,
	input  wire logic              i_ia_ready,
	input  wire logic [DATA_W-1:0] i_ia_rdata,
	input  wire logic              i_db_request,
	input  wire logic              i_db_rw,
	input  wire logic [ADDR_W-1:0] i_db_address,
	input  wire logic [DATA_W-1:0] i_db_wdata,
	input  wire logic              i_db_ready,
	input  wire logic [DATA_W-1:0] i_db_rdata,
	input  wire logic [LED_W-1:0]  i_led,
	input  wire logic              i_both,
	input  wire logic              i_check_a,
	input  wire logic [DATA_W-1:0] i_exp_a,
	input  wire logic              i_check_b,
	input  wire logic [DATA_W-1:0] i_exp_b,
	output int                     o_errors,
	output int                     o_reads
);

	localparam logic [ADDR_W-1:0] LED_ADDR   = PERIPH_BASE + ADDR_W'(REG_LED);
	localparam logic [ADDR_W-1:0] COUNT_ADDR = PERIPH_BASE + ADDR_W'(REG_COUNT);

	logic [DATA_W-1:0] shadow_mem [RAM_DEPTH];
	logic [LED_W-1:0]  shadow_led;
	logic [DATA_W-1:0] last_count;
	bit                have_count;
	int                errors = 0;
	int                reads = 0;

	assign o_errors = errors;
	assign o_reads  = reads;

	function automatic bit in_ram(input logic [ADDR_W-1:0] addr);
		return (addr >= RAM_BASE) && (addr < RAM_BASE + RAM_SPAN);
	endfunction

	// Byte offset to word, wrapped at the RAM depth
	function automatic int ram_index(input logic [ADDR_W-1:0] addr);
		return int'(((addr - RAM_BASE) >> 2) % RAM_DEPTH);
	endfunction

	task automatic compare_value(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] expv);
		reads++;
		if (got !== expv)
		begin
			$display("FAIL %s: got 0x%08h, expected 0x%08h at %0t", name, got, expv, $time);
			errors++;
		end
	endtask

	// ========================================
	// Port B completion
	// ========================================
	task automatic data_done();
		if (i_db_rw)
		begin
			if (in_ram(i_db_address))
				shadow_mem[ram_index(i_db_address)] = i_db_wdata;
			else if (i_db_address == LED_ADDR)
				shadow_led = i_db_wdata[LED_W-1:0];
		end
		else if (i_check_b)
			compare_value("o_db_rdata", i_db_rdata, i_exp_b);
		else if (in_ram(i_db_address))
			compare_value("o_db_rdata", i_db_rdata, shadow_mem[ram_index(i_db_address)]);
		else if (i_db_address == LED_ADDR)
			compare_value("o_db_rdata", i_db_rdata, DATA_W'(shadow_led));
		else if (i_db_address == COUNT_ADDR)
		begin
			if (have_count && i_db_rdata <= last_count)
			begin
				$display("Timer count did not advance between two reads (0x%08h then 0x%08h)",
					last_count, i_db_rdata);
				errors++;
			end
			last_count = i_db_rdata;
			have_count = 1'b1;
		end
	endtask

	task automatic fetch_done();
		// Port B holds its request until its own ready
		if (i_both && i_db_request)
		begin
			$display("Port A completed before port B on a simultaneous request at %0t", $time);
			errors++;
		end
		if (i_check_a)
			compare_value("o_ia_rdata", i_ia_rdata, i_exp_a);
		else if (in_ram(i_ia_address))
			compare_value("o_ia_rdata", i_ia_rdata, shadow_mem[ram_index(i_ia_address)]);
	endtask

	always @(posedge clock)
	begin
		if (i_rst)
		begin
			shadow_led = '0;
			have_count = 1'b0;
		end
		else
		begin
			if (i_db_ready)
				data_done();
			if (i_ia_ready)
				fetch_done();
			if (i_led !== shadow_led)
			begin
				$display("FAIL o_led: got 0x%03h, expected 0x%03h at %0t", i_led, shadow_led,
					$time);
				errors++;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc
	import soc_pkg::*;
();

	localparam int RAM_DEPTH    = 1024;
	localparam int TICK_DIV     = 4;
	localparam int RESET_CYCLES = 5;
	localparam int COMPARE_GAP  = 8;

	localparam logic [ADDR_W-1:0] RAM_A     = RAM_BASE;
	localparam logic [ADDR_W-1:0] LED_A     = PERIPH_BASE + ADDR_W'(REG_LED);
	localparam logic [ADDR_W-1:0] COUNT_A   = PERIPH_BASE + ADDR_W'(REG_COUNT);
	localparam logic [ADDR_W-1:0] COMPARE_A = PERIPH_BASE + ADDR_W'(REG_COMPARE);
	localparam logic [ADDR_W-1:0] STATUS_A  = PERIPH_BASE + ADDR_W'(REG_STATUS);
	localparam logic [ADDR_W-1:0] NONE_A    = 32'h3000_0000;

	typedef enum logic [1:0] {ROW_A, ROW_B, ROW_BOTH, ROW_WAIT} kind_t;

	// One access or one idle stretch; wdata holds the cycle count on waits
	typedef struct {
		kind_t             kind;
		bit                wr;
		bit                rel;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [DATA_W-1:0] expv;
		bit                chk;
	} row_t;

	logic              clock;
	logic              rst;
	logic              ia_request;
	logic [ADDR_W-1:0] ia_address;
	logic              ia_ready;
	logic [DATA_W-1:0] ia_rdata;
	logic              db_request;
	logic              db_rw;
	logic [ADDR_W-1:0] db_address;
	logic [DATA_W-1:0] db_wdata;
	logic              db_ready;
	logic [DATA_W-1:0] db_rdata;
	logic [LED_W-1:0]  led;

	logic              both_row;
	logic              check_a;
	logic              check_b;
	logic [DATA_W-1:0] exp_a;
	logic [DATA_W-1:0] exp_b;
	logic [DATA_W-1:0] last_b_rdata;
	int                errors;
	int                reads;
	longint            limit_ns;
	row_t              rows [$];

	soc_top #(.RAM_DEPTH(RAM_DEPTH), .TICK_DIV(TICK_DIV)) uut (
		.clock        (clock),
		.i_rst        (rst),
		.i_ia_request (ia_request),
		.i_ia_address (ia_address),
		.o_ia_ready   (ia_ready),
		.o_ia_rdata   (ia_rdata),
		.i_db_request (db_request),
		.i_db_rw      (db_rw),
		.i_db_address (db_address),
		.i_db_wdata   (db_wdata),
		.o_db_ready   (db_ready),
		.o_db_rdata   (db_rdata),
		.o_led        (led)
	);

	soc_checker #(.RAM_DEPTH(RAM_DEPTH)) u_checker (
		.clock        (clock),
		.i_rst        (rst),
		.i_ia_address (ia_address),
		.i_ia_ready   (ia_ready),
		.i_ia_rdata   (ia_rdata),
		.i_db_request (db_request),
		.i_db_rw      (db_rw),
		.i_db_address (db_address),
		.i_db_wdata   (db_wdata),
		.i_db_ready   (db_ready),
		.i_db_rdata   (db_rdata),
		.i_led        (led),
		.i_both       (both_row),
		.i_check_a    (check_a),
		.i_exp_a      (exp_a),
		.i_check_b    (check_b),
		.i_exp_b      (exp_b),
		.o_errors     (errors),
		.o_reads      (reads)
	);

	initial
		clock = 1'b0;
	always #10 clock = ~clock;

	function automatic void add_row(kind_t kind, bit wr, bit rel, logic [ADDR_W-1:0] addr,
		logic [DATA_W-1:0] wdata, logic [DATA_W-1:0] expv, bit chk);
		row_t r;
		r = '{kind, wr, rel, addr, wdata, expv, chk};
		rows.push_back(r);
	endfunction

	// ========================================
	// Stimulus table
	// ========================================
	task automatic build_table();
		logic [DATA_W-1:0] d0;
		logic [DATA_W-1:0] d1;
		logic [DATA_W-1:0] d2;
		logic [DATA_W-1:0] d3;
		d0 = $urandom();
		d1 = $urandom();
		d2 = $urandom();
		d3 = $urandom();
		add_row(ROW_B, 1, 0, RAM_A + 32'h0, d0, 0, 0);
		add_row(ROW_B, 0, 0, RAM_A + 32'h0, 0, 0, 0);
		add_row(ROW_B, 1, 0, RAM_A + 32'h40, d1, 0, 0);
		add_row(ROW_B, 0, 0, RAM_A + 32'h40, 0, 0, 0);
		// One RAM depth further up lands on word 2
		add_row(ROW_B, 1, 0, RAM_A + 32'(RAM_DEPTH * 4) + 32'h8, d2, 0, 0);
		add_row(ROW_B, 0, 0, RAM_A + 32'h8, 0, d2, 1);
		add_row(ROW_A, 0, 0, RAM_A + 32'h0, 0, 0, 0);
		add_row(ROW_A, 0, 0, RAM_A + 32'h40, 0, 0, 0);
		// Port B write wins the tie, port A then fetches the new word
		add_row(ROW_BOTH, 1, 0, RAM_A + 32'h80, d3, d3, 1);
		add_row(ROW_BOTH, 0, 0, RAM_A + 32'h0, 0, 0, 0);
		add_row(ROW_B, 1, 0, LED_A, 32'hFFFF_F2A5, 0, 0);
		add_row(ROW_B, 0, 0, LED_A, 0, 32'h0000_02A5, 1);
		add_row(ROW_B, 0, 0, COUNT_A, 0, 0, 0);
		add_row(ROW_WAIT, 0, 0, 0, 20, 0, 0);
		add_row(ROW_B, 0, 0, COUNT_A, 0, 0, 0);
		add_row(ROW_B, 1, 1, COMPARE_A, COMPARE_GAP, 0, 0);
		add_row(ROW_WAIT, 0, 0, 0, TICK_DIV * COMPARE_GAP + 16, 0, 0);
		add_row(ROW_B, 0, 0, STATUS_A, 0, 32'h1, 1);
		add_row(ROW_B, 1, 0, STATUS_A, 32'h1, 0, 0);
		add_row(ROW_B, 0, 0, STATUS_A, 0, 32'h0, 1);
		add_row(ROW_B, 0, 0, NONE_A, 0, 32'h0, 1);
		add_row(ROW_A, 0, 0, NONE_A, 0, 32'h0, 1);
	endtask

	// Drive one row at a falling edge and hold each request until its ready
	task automatic run_access(input row_t r);
		bit a_busy;
		bit b_busy;
		a_busy   = (r.kind != ROW_B);
		b_busy   = (r.kind != ROW_A);
		both_row = (r.kind == ROW_BOTH);
		if (a_busy)
		begin
			ia_request = 1'b1;
			ia_address = r.addr;
			check_a    = r.chk;
			exp_a      = r.expv;
		end
		if (b_busy)
		begin
			db_request = 1'b1;
			db_rw      = r.wr;
			db_address = r.addr;
			db_wdata   = r.rel ? last_b_rdata + r.wdata : r.wdata;
			check_b    = r.chk && !r.wr;
			exp_b      = r.expv;
		end
		while (a_busy || b_busy)
		begin
			@(negedge clock);
			if (!a_busy)
				ia_request = 1'b0;
			if (!b_busy)
				db_request = 1'b0;
			if (a_busy && ia_ready)
				a_busy = 1'b0;
			if (b_busy && db_ready)
			begin
				b_busy       = 1'b0;
				last_b_rdata = db_rdata;
			end
		end
		@(negedge clock);
		ia_request = 1'b0;
		db_request = 1'b0;
		both_row   = 1'b0;
		check_a    = 1'b0;
		check_b    = 1'b0;
	endtask

	initial
	begin
		int wait_total;
		int rows_run;
		limit_ns     = 0;
		rst          = 1'b1;
		ia_request   = 1'b0;
		ia_address   = '0;
		db_request   = 1'b0;
		db_rw        = 1'b0;
		db_address   = '0;
		db_wdata     = '0;
		both_row     = 1'b0;
		check_a      = 1'b0;
		check_b      = 1'b0;
		exp_a        = '0;
		exp_b        = '0;
		last_b_rdata = '0;
		wait_total   = 0;
		rows_run     = 0;
		void'($urandom(87549));
		build_table();
		foreach (rows[i])
			if (rows[i].kind == ROW_WAIT)
				wait_total += int'(rows[i].wdata);
		limit_ns = longint'(rows.size() * 40 + RESET_CYCLES + wait_total) * 20;

		repeat (RESET_CYCLES) @(negedge clock);
		rst = 1'b0;

		foreach (rows[i])
		begin
			if (rows[i].kind == ROW_WAIT)
				repeat (rows[i].wdata) @(negedge clock);
			else
				run_access(rows[i]);
			rows_run++;
		end

		$display("Rows run: %0d, reads checked: %0d, errors: %0d", rows_run, reads, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("Timeout: the stimulus table did not finish within %0d ns", limit_ns);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
common/soc_pkg.sv
common/bus_if.sv
source/bus_access.sv
source/bus_decoder.sv
source/block_ram.sv
peripherals/periph_regs.sv
peripherals/cycle_timer.sv
source/soc_top.sv
tb/soc_checker.sv
tb/tb_soc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_soc \
	-o tb_soc_sim > build.log 2>&1 \
	&& ./obj_dir/tb_soc_sim > sim.log 2>&1 \
	|| echo "Build or simulation run failed, see build.log and sim.log"
grep -qx ">>> PASS" sim.log && echo "Simulation passed" && exit 0 \
	|| { echo "Simulation failed"; exit 1; }
